// ==== rtl/uart_tx_config.svh ====
`ifndef UART_TX_CONFIG_SVH
`define UART_TX_CONFIG_SVH

// frame payload size, lsb goes out first
`define UART_DATA_BITS 8

// transmit buffer entries, keep a power of two
`define UART_FIFO_DEPTH 4

`endif

// ==== rtl/uart_tx_pkg.sv ====
`default_nettype none

`include "uart_tx_config.svh"

package uart_tx_pkg;

    // one payload byte as it moves from producer to line
    typedef logic [`UART_DATA_BITS-1:0] tx_byte_t;

    // frame sequencing states
    typedef enum logic [2:0] {
        IDLE      = 3'b000,    // waiting for a queued byte
        LOAD      = 3'b001,    // pop fifo, capture byte
        START_BIT = 3'b010,    // line low
        DATA_BITS = 3'b011,    // payload, lsb first
        STOP_BIT  = 3'b100     // line high
    } state_t;

endpackage

`default_nettype wire

// ==== rtl/uart_tx_fifo.sv ====
`default_nettype none

`include "uart_tx_config.svh"

module uart_tx_fifo
    import uart_tx_pkg::*;
#(
    parameter type payload_t = tx_byte_t,
    parameter int  DEPTH     = `UART_FIFO_DEPTH
) (
    input  logic     div_clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,     // not full
    output payload_t out_data,     // head entry
    output logic     out_valid,    // not empty
    input  logic     out_pop
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_pop && out_valid;

    always_ff @(posedge div_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_fsm.sv ====
`default_nettype none

module uart_fsm
    import uart_tx_pkg::*;
(
    input  logic div_clk,
    input  logic rst_n,
    input  logic tx_valid,       // byte waiting in fifo
    input  logic count_done,     // last data bit on the line
    output logic load,           // pop fifo into shifter
    output logic start_shift,    // present and shift data bits
    output logic start_count,    // bit counter enable
    output logic start,          // hold line low
    output logic tx_ready,
    output logic tx_busy
);

    state_t state;
    state_t next_state;

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (tx_valid) begin
                    next_state = LOAD;
                end
            end
            LOAD:      next_state = START_BIT;
            START_BIT: next_state = DATA_BITS;
            DATA_BITS: begin
                if (count_done) begin
                    next_state = STOP_BIT;    // eighth bit is going out now
                end
            end
            STOP_BIT:  next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // Moore outputs, decoded from the current state only
    always_comb begin
        load        = 1'b0;
        start_shift = 1'b0;
        start_count = 1'b0;
        start       = 1'b0;
        tx_ready    = 1'b0;
        tx_busy     = 1'b0;
        case (state)
            IDLE: begin
                tx_ready = 1'b1;
            end
            LOAD: begin
                load    = 1'b1;
                tx_busy = 1'b1;
            end
            START_BIT: begin
                start       = 1'b1;
                start_count = 1'b1;
                tx_busy     = 1'b1;
            end
            DATA_BITS: begin
                start_shift = 1'b1;
                start_count = 1'b1;
                tx_busy     = 1'b1;
            end
            STOP_BIT: begin
                tx_busy = 1'b1;    // shifter idles the line high
            end
            default: begin
                tx_busy = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_shifter.sv ====
`default_nettype none

`include "uart_tx_config.svh"

module uart_tx_shifter
    import uart_tx_pkg::*;
(
    input  logic     div_clk,
    input  logic     rst_n,
    input  logic     load,          // capture load_data, clear counter
    input  tx_byte_t load_data,
    input  logic     start,         // start bit
    input  logic     start_shift,   // data bit phase
    input  logic     start_count,
    output logic     count_done,
    output logic     tx_serial
);

    localparam int CNT_W = $clog2(`UART_DATA_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`UART_DATA_BITS - 1);

    tx_byte_t         shift_reg;
    logic [CNT_W-1:0] bit_cnt;      // index of bit currently on the line

    always_ff @(posedge div_clk) begin
        if (load) begin
            shift_reg <= load_data;
        end else if (start_shift) begin
            shift_reg <= shift_reg >> 1;    // next bit into position 0
        end
    end

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (start_count && start_shift) begin
            bit_cnt <= bit_cnt + 1'b1;      // wraps to zero after last bit
        end
    end

    assign count_done = start_shift && (bit_cnt == LAST_BIT);

    // idle and stop level is high
    always_comb begin
        if (start) begin
            tx_serial = 1'b0;
        end else if (start_shift) begin
            tx_serial = shift_reg[0];
        end else begin
            tx_serial = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx_top.sv ====
`default_nettype none

module uart_tx_top
    import uart_tx_pkg::*;
(
    input  logic     div_clk,
    input  logic     rst_n,
    input  tx_byte_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output logic     tx_serial,
    output logic     tx_busy
);

    tx_byte_t fifo_data;
    logic     fifo_valid;
    logic     load;         // fifo pop and shifter capture
    logic     start;
    logic     start_shift;
    logic     start_count;
    logic     count_done;
    logic     tx_ready;     // only watched by assertions

    uart_tx_fifo #(
        .payload_t (tx_byte_t)
    ) i_uart_tx_fifo (
        .div_clk   (div_clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (fifo_data),
        .out_valid (fifo_valid),
        .out_pop   (load)
    );

    uart_fsm i_uart_fsm (
        .div_clk     (div_clk),
        .rst_n       (rst_n),
        .tx_valid    (fifo_valid),
        .count_done  (count_done),
        .load        (load),
        .start_shift (start_shift),
        .start_count (start_count),
        .start       (start),
        .tx_ready    (tx_ready),
        .tx_busy     (tx_busy)
    );

    uart_tx_shifter i_uart_tx_shifter (
        .div_clk     (div_clk),
        .rst_n       (rst_n),
        .load        (load),
        .load_data   (fifo_data),
        .start       (start),
        .start_shift (start_shift),
        .start_count (start_count),
        .count_done  (count_done),
        .tx_serial   (tx_serial)
    );

endmodule

`default_nettype wire

// ==== tb/uart_tx_props.sv ====
`default_nettype none

`include "uart_tx_config.svh"

module uart_tx_props
    import uart_tx_pkg::*;
(
    input logic   div_clk,
    input logic   rst_n,
    input state_t state,
    input logic   load,
    input logic   count_done,
    input logic   tx_ready,
    input logic   tx_busy,
    input logic   tx_serial,
    input logic   in_valid,
    input logic   in_ready,
    input logic   fifo_valid
);

    int occ;    // fifo occupancy rebuilt from the handshakes

    always_ff @(posedge div_clk or negedge rst_n) begin
        if (!rst_n) begin
            occ <= 0;
        end else begin
            occ <= occ + int'(in_valid && in_ready) - int'(load && fifo_valid);
        end
    end

    ready_busy_exclusive: assert property (@(posedge div_clk) disable iff (!rst_n)
        !(tx_ready && tx_busy)) else $error("tx_ready and tx_busy high together");

    load_then_start: assert property (@(posedge div_clk) disable iff (!rst_n)
        load |=> state == START_BIT) else $error("load not followed by START_BIT");

    line_low_after_load: assert property (@(posedge div_clk) disable iff (!rst_n)
        load |=> !tx_serial) else $error("line not low after load");

    done_in_data: assert property (@(posedge div_clk) disable iff (!rst_n)
        count_done |-> state == DATA_BITS) else $error("count_done outside DATA_BITS");

    ready_low_only_full: assert property (@(posedge div_clk) disable iff (!rst_n)
        !in_ready |-> occ == `UART_FIFO_DEPTH) else $error("in_ready low with fifo not full");

endmodule

bind uart_tx_top uart_tx_props i_uart_tx_props (
    .div_clk    (div_clk),
    .rst_n      (rst_n),
    .state      (i_uart_fsm.state),
    .load       (load),
    .count_done (count_done),
    .tx_ready   (tx_ready),
    .tx_busy    (tx_busy),
    .tx_serial  (tx_serial),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .fifo_valid (fifo_valid)
);

`default_nettype wire

// ==== tb/uart_tx_tb.sv ====
`default_nettype none

`include "uart_tx_config.svh"

module uart_tx_tb
    import uart_tx_pkg::*;
();

    localparam int NUM_TESTS       = 6;
    localparam int MAX_BYTES       = 7;
    localparam int SEED            = 3943;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_BYTES * 14 + 400;

    logic     div_clk;
    logic     rst_n;
    tx_byte_t in_data;
    logic     in_valid;
    logic     in_ready;
    logic     tx_serial;
    logic     tx_busy;

    string    test_name [NUM_TESTS];
    int       num_bytes [NUM_TESTS];
    bit       burst     [NUM_TESTS];    // push on every cycle the fifo allows
    bit       mid_reset [NUM_TESTS];
    tx_byte_t push_data [NUM_TESTS][MAX_BYTES];

    tx_byte_t expected_q[$];            // bytes accepted, not yet seen on the line
    int       gap_q[$];                 // high cycles before each later frame
    string    current_test;
    bit       first_frame;
    bit       full_seen;
    int       frames_seen;
    int       value_errors;
    int       other_errors;

    uart_tx_top i_uart_tx_top (
        .div_clk   (div_clk),
        .rst_n     (rst_n),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .tx_serial (tx_serial),
        .tx_busy   (tx_busy)
    );

    initial begin
        div_clk = 1'b0;
        forever #5 div_clk = ~div_clk;
    end

    task automatic report_value(input string what, input int expected, input int actual);
        $display("FAILED %s: %s expected 0x%0h got 0x%0h", current_test, what, expected, actual);
        value_errors++;
    endtask

    task automatic report_other(input string msg);
        $display("ERROR in %s: %s", current_test, msg);
        other_errors++;
    endtask

    task automatic set_entry(input int idx, input string name, input int n,
                             input bit is_burst, input bit with_reset);
        test_name[idx] = name;
        num_bytes[idx] = n;
        burst[idx]     = is_burst;
        mid_reset[idx] = with_reset;
    endtask

    task automatic build_table();
        int t;
        int j;
        for (t = 0; t < NUM_TESTS; t++) begin
            for (j = 0; j < MAX_BYTES; j++) begin
                push_data[t][j] = tx_byte_t'($urandom);
            end
        end
        push_data[0][0] = 8'hA5;
        set_entry(0, "single_a5", 1, 1'b0, 1'b0);
        set_entry(1, "single_random", 3, 1'b0, 1'b0);
        set_entry(2, "burst_3", 3, 1'b1, 1'b0);
        set_entry(3, "backpressure_7", 7, 1'b1, 1'b0);
        set_entry(4, "reset_mid_frame", 3, 1'b1, 1'b1);
        set_entry(5, "after_reset", 1, 1'b0, 1'b0);
    endtask

    // line must stay high with nothing in flight
    task automatic check_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(negedge div_clk);
            if (tx_serial !== 1'b1) report_value("idle tx_serial", 1, int'(tx_serial));
            if (tx_busy !== 1'b0) report_value("idle tx_busy", 0, int'(tx_busy));
            if (in_ready !== 1'b1) report_value("idle in_ready", 1, int'(in_ready));
        end
        @(posedge div_clk);
        #1;
    endtask

    task automatic push_byte(input tx_byte_t b);
        bit accepted;
        accepted = 1'b0;
        in_data  = b;
        in_valid = 1'b1;
        while (!accepted) begin
            @(negedge div_clk);
            accepted = in_ready;                // in_ready only moves on the clock
            if (!in_ready) full_seen = 1'b1;
            @(posedge div_clk);
            #1;
        end
        expected_q.push_back(b);
    endtask

    task automatic wait_idle();
        do begin
            @(negedge div_clk);
        end while (expected_q.size() != 0 || tx_busy);
        @(posedge div_clk);
        #1;
    endtask

    task automatic capture_frame(input int gap, output bit complete);
        tx_byte_t rx;
        tx_byte_t exp_byte;
        int       i;
        rx       = '0;
        complete = 1'b0;
        if (!first_frame) gap_q.push_back(gap);
        first_frame = 1'b0;
        if (tx_busy !== 1'b1) report_value("tx_busy in start bit", 1, int'(tx_busy));
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            @(negedge div_clk);
            if (!rst_n) return;                 // frame cut by reset
            rx[i] = tx_serial;                  // lsb first
            if (tx_busy !== 1'b1) report_value("tx_busy in data bit", 1, int'(tx_busy));
        end
        @(negedge div_clk);
        if (!rst_n) return;
        if (tx_serial !== 1'b1) report_value("stop bit", 1, int'(tx_serial));
        if (tx_busy !== 1'b1) report_value("tx_busy in stop bit", 1, int'(tx_busy));
        frames_seen++;
        if (expected_q.size() == 0) begin
            report_other("a frame went out with no byte pending");
        end else begin
            exp_byte = expected_q.pop_front();
            if (rx !== exp_byte) report_value("frame data", int'(exp_byte), int'(rx));
        end
        complete = 1'b1;
    endtask

    initial begin : frame_monitor
        int high_run;
        bit complete;
        high_run = 0;
        forever begin
            @(negedge div_clk);
            if (!rst_n) begin
                high_run = 0;
            end else if (tx_serial === 1'b1) begin
                high_run++;
            end else begin
                capture_frame(high_run, complete);
                high_run = complete ? 1 : 0;    // stop bit is the first high cycle
            end
        end
    end

    // reset lands a few bits into the data phase
    task automatic apply_mid_reset();
        do begin
            @(negedge div_clk);
        end while (tx_serial !== 1'b0);
        repeat (3) @(posedge div_clk);
        #1;
        rst_n = 1'b0;
        #1;
        if (tx_serial !== 1'b1) report_value("tx_serial in reset", 1, int'(tx_serial));
        if (tx_busy !== 1'b0) report_value("tx_busy in reset", 0, int'(tx_busy));
        if (in_ready !== 1'b1) report_value("in_ready in reset", 1, int'(in_ready));
        expected_q.delete();                    // queued bytes are gone
        repeat (2) @(posedge div_clk);
        #1;
        rst_n = 1'b1;
    endtask

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge div_clk);
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_sequence
        int t;
        int j;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_data      = '0;
        current_test = "after_power_on";
        first_frame  = 1'b1;
        full_seen    = 1'b0;
        frames_seen  = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));
        build_table();
        repeat (8) @(posedge div_clk);
        #1;
        rst_n = 1'b1;
        check_idle(6);
        for (t = 0; t < NUM_TESTS; t++) begin
            current_test = test_name[t];
            first_frame  = 1'b1;
            full_seen    = 1'b0;
            gap_q.delete();
            for (j = 0; j < num_bytes[t]; j++) begin
                push_byte(push_data[t][j]);
                if (!burst[t]) begin
                    in_valid = 1'b0;
                    wait_idle();
                end
            end
            in_valid = 1'b0;
            if (mid_reset[t]) begin
                apply_mid_reset();
            end else begin
                wait_idle();
                if (burst[t]) begin
                    if (gap_q.size() != num_bytes[t] - 1) begin
                        report_value("frame gaps seen", num_bytes[t] - 1, gap_q.size());
                    end
                    foreach (gap_q[k]) begin
                        if (gap_q[k] != 3) report_value("high cycles between frames", 3, gap_q[k]);
                    end
                end
                if (burst[t] && num_bytes[t] > `UART_FIFO_DEPTH && !full_seen) begin
                    report_other("in_ready never dropped while the fifo was full");
                end
            end
            check_idle(mid_reset[t] ? 20 : 4);  // discarded bytes must not appear
        end
        $display("summary: %0d frames, %0d value errors, %0d other errors",
                 frames_seen, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/uart_tx_pkg.sv
rtl/uart_tx_fifo.sv
rtl/uart_fsm.sv
rtl/uart_tx_shifter.sv
rtl/uart_tx_top.sv
tb/uart_tx_props.sv
tb/uart_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module uart_tx_tb -o uart_tx_sim

./obj_dir/uart_tx_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
